//--- verilog/bfp_pkg.sv
package bfp_pkg;

  // ============================================================
  // Widths and block geometry.
  // ============================================================

  // Two's-complement mantissa, same width in and out.
  localparam int MAN_W      = 8;
  localparam int EXP_W      = 8;
  // One extra bit for the increment from halving.
  localparam int OEXP_W     = EXP_W + 1;
  localparam int BLOCK_SIZE = 6;

  localparam int SHIFT_W    = OEXP_W;
  // Holds a normalization count up to MAN_W - 1.
  localparam int NORM_W     = $clog2(MAN_W);

  // Most negative output exponent, floor for normalization.
  localparam logic signed [OEXP_W-1:0] OEXP_MIN = {1'b1, {(OEXP_W-1){1'b0}}};

  // ============================================================
  // Block types.
  // ============================================================

  // Lane 0 sits in the low bits.
  typedef logic [BLOCK_SIZE-1:0][MAN_W-1:0] man_block_t;

  typedef struct packed {
    man_block_t       man;
    logic [EXP_W-1:0] exp;
  } bfp_in_t;

  typedef struct packed {
    man_block_t        man;
    logic [OEXP_W-1:0] exp;
  } bfp_out_t;

  // Joined operands, ready for the lane adders.
  typedef struct packed {
    man_block_t         a_man;
    man_block_t         b_man;
    logic [SHIFT_W-1:0] a_shift;
    logic [SHIFT_W-1:0] b_shift;
    logic [OEXP_W-1:0]  max_exp;
  } bfp_pair_t;

endpackage

//--- verilog/bfp_lane_adder.sv
`timescale 1ns/10ps

module bfp_lane_adder (
  input  logic [bfp_pkg::MAN_W-1:0]   a_man,
  input  logic [bfp_pkg::MAN_W-1:0]   b_man,
  input  logic [bfp_pkg::SHIFT_W-1:0] a_shift,
  input  logic [bfp_pkg::SHIFT_W-1:0] b_shift,
  output logic [bfp_pkg::MAN_W-1:0]   sum
);

  import bfp_pkg::*;

  logic [NORM_W-1:0]       a_amt;
  logic [NORM_W-1:0]       b_amt;
  logic signed [MAN_W-1:0] a_aligned;
  logic signed [MAN_W-1:0] b_aligned;
  logic signed [MAN_W:0]   sum_wide;

  // Shifts past MAN_W - 1 leave only sign fill.
  assign a_amt = (a_shift >= SHIFT_W'(MAN_W - 1)) ? NORM_W'(MAN_W - 1)
                                                  : a_shift[NORM_W-1:0];
  assign b_amt = (b_shift >= SHIFT_W'(MAN_W - 1)) ? NORM_W'(MAN_W - 1)
                                                  : b_shift[NORM_W-1:0];

  assign a_aligned = $signed(a_man) >>> a_amt;
  assign b_aligned = $signed(b_man) >>> b_amt;

  // One guard bit, then halve.
  assign sum_wide = {a_aligned[MAN_W-1], a_aligned} + {b_aligned[MAN_W-1], b_aligned};
  assign sum      = sum_wide[MAN_W:1];

endmodule

//--- verilog/bfp_operand_join.sv
`timescale 1ns/10ps

module bfp_operand_join (
  input  logic               clk,
  input  logic               reset,

  input  bfp_pkg::bfp_in_t   a_block,
  input  logic               a_valid,
  output logic               a_ready,

  input  bfp_pkg::bfp_in_t   b_block,
  input  logic               b_valid,
  output logic               b_ready,

  output bfp_pkg::bfp_pair_t pair,
  output logic               pair_valid,
  input  logic               pair_ready
);

  import bfp_pkg::*;

  logic                     slot_ready;
  logic                     join_fire;
  logic signed [OEXP_W-1:0] a_exp_ext;
  logic signed [OEXP_W-1:0] b_exp_ext;
  logic signed [OEXP_W-1:0] max_exp;
  bfp_pair_t                pair_d;

  // Slot is free or drains this cycle.
  assign slot_ready = !pair_valid || pair_ready;

  // Each side waits for its partner.
  assign a_ready   = b_valid && slot_ready;
  assign b_ready   = a_valid && slot_ready;
  assign join_fire = a_valid && b_valid && slot_ready;

  // ============================================================
  // Exponent compare and alignment shifts.
  // ============================================================

  assign a_exp_ext = {a_block.exp[EXP_W-1], a_block.exp};
  assign b_exp_ext = {b_block.exp[EXP_W-1], b_block.exp};
  assign max_exp   = (a_exp_ext > b_exp_ext) ? a_exp_ext : b_exp_ext;

  always_comb begin
    pair_d.a_man   = a_block.man;
    pair_d.b_man   = b_block.man;
    // The difference is never negative.
    pair_d.a_shift = max_exp - a_exp_ext;
    pair_d.b_shift = max_exp - b_exp_ext;
    pair_d.max_exp = max_exp;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_valid <= 1'b0;
      pair       <= '0;
    end else begin
      if (slot_ready) begin
        pair_valid <= join_fire;
      end
      if (join_fire) begin
        pair <= pair_d;
      end
    end
  end

  // Operands are consumed together or not at all.
  a_b_ready_match: assert property (
    @(posedge clk) disable iff (reset)
    (a_valid && b_valid) |-> (a_ready == b_ready)
  ) else $error("join: a_ready and b_ready differ with both operands valid");

endmodule

//--- verilog/bfp_block_normalize.sv
`timescale 1ns/10ps

module bfp_block_normalize (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic [bfp_pkg::BLOCK_SIZE-1:0][bfp_pkg::MAN_W-1:0] sums,
  input  logic [bfp_pkg::OEXP_W-1:0]                         max_exp,
  output bfp_pkg::bfp_out_t                                  result
);

  import bfp_pkg::*;

  // Leading bits equal to the sign, minus one.
  function automatic logic [NORM_W-1:0] sign_bits(input logic [MAN_W-1:0] m);
    logic [NORM_W-1:0] cnt;
    logic              run;
    cnt = '0;
    run = 1'b1;
    for (int j = MAN_W - 2; j >= 0; j--) begin
      if (run && (m[j] == m[MAN_W-1])) begin
        cnt = cnt + 1'b1;
      end else begin
        run = 1'b0;
      end
    end
    return cnt;
  endfunction

  logic [BLOCK_SIZE-1:0][NORM_W-1:0] lane_k;
  logic [NORM_W-1:0]                 block_k;
  logic signed [OEXP_W:0]            prov_exp;
  logic signed [OEXP_W:0]            headroom;
  logic [NORM_W-1:0]                 k;
  logic signed [OEXP_W:0]            exp_wide;
  logic                              floor_ok;
  logic                              sign_ok;

  // ============================================================
  // Common shift across the block.
  // ============================================================

  always_comb begin
    block_k = NORM_W'(MAN_W - 1);
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      lane_k[i] = sign_bits(sums[i]);
      if (lane_k[i] < block_k) begin
        block_k = lane_k[i];
      end
    end
  end

  // Halving raised the exponent by one.
  assign prov_exp = {max_exp[OEXP_W-1], max_exp} + (OEXP_W + 1)'(1);
  assign headroom = prov_exp - {OEXP_MIN[OEXP_W-1], OEXP_MIN};

  // Do not push the exponent below the floor.
  assign k = (headroom < $signed({{(OEXP_W + 1 - NORM_W){1'b0}}, block_k}))
             ? headroom[NORM_W-1:0] : block_k;

  assign exp_wide = prov_exp - {{(OEXP_W + 1 - NORM_W){1'b0}}, k};

  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      result.man[i] = sums[i] << k;
    end
    result.exp = exp_wide[OEXP_W-1:0];
  end

  always_comb begin
    floor_ok = (exp_wide >= $signed({OEXP_MIN[OEXP_W-1], OEXP_MIN}));
    sign_ok  = 1'b1;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      if (result.man[i][MAN_W-1] != sums[i][MAN_W-1]) begin
        sign_ok = 1'b0;
      end
    end
  end

  norm_range: assert property (
    @(posedge clk) disable iff (reset)
    floor_ok && sign_ok
  ) else $error("normalize: exponent below floor or mantissa sign flipped");

endmodule

//--- verilog/bfp_skid_buffer.sv
`timescale 1ns/10ps

module bfp_skid_buffer (
  input  logic              clk,
  input  logic              reset,

  input  bfp_pkg::bfp_out_t in_data,
  input  logic              in_valid,
  output logic              in_ready,

  output bfp_pkg::bfp_out_t out_data,
  output logic              out_valid,
  input  logic              out_ready
);

  import bfp_pkg::*;

  bfp_out_t main_data;
  bfp_out_t skid_data;
  logic     main_valid;
  logic     skid_valid;
  logic     ready_q;

  logic     main_free;
  logic     in_fire;
  logic     main_valid_d;
  logic     skid_valid_d;

  assign in_ready  = ready_q;
  assign out_data  = main_data;
  assign out_valid = main_valid;

  // ============================================================
  // Occupancy control.
  // ============================================================

  always_comb begin
    main_free    = !main_valid || out_ready;
    in_fire      = in_valid && ready_q;
    main_valid_d = main_valid;
    skid_valid_d = skid_valid;
    if (main_free) begin
      // Skid drains first, ready was low meanwhile.
      main_valid_d = skid_valid || in_fire;
      skid_valid_d = 1'b0;
    end else if (in_fire) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      main_valid <= main_valid_d;
      skid_valid <= skid_valid_d;
      ready_q    <= !skid_valid_d;
    end
  end

  // Payload.
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (in_fire) begin
        main_data <= in_data;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
    end
  end

  out_hold: assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("skid: out_data changed while stalled");

endmodule

//--- verilog/bfp_adder_top.sv
`timescale 1ns/10ps

module bfp_adder_top (
  input  logic              clk,
  input  logic              reset,

  input  bfp_pkg::bfp_in_t  a_block,
  input  logic              a_valid,
  output logic              a_ready,

  input  bfp_pkg::bfp_in_t  b_block,
  input  logic              b_valid,
  output logic              b_ready,

  output bfp_pkg::bfp_out_t out_block,
  output logic              out_valid,
  input  logic              out_ready
);

  import bfp_pkg::*;

  bfp_pair_t  pair;
  logic       pair_valid;
  logic       pair_ready;
  man_block_t sums;
  bfp_out_t   norm_result;

  // ============================================================
  // Join and register the operand pair.
  // ============================================================

  bfp_operand_join u_join (
    .clk        (clk),
    .reset      (reset),
    .a_block    (a_block),
    .a_valid    (a_valid),
    .a_ready    (a_ready),
    .b_block    (b_block),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .pair       (pair),
    .pair_valid (pair_valid),
    .pair_ready (pair_ready)
  );

  // One adder per mantissa.
  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : lanes
    bfp_lane_adder u_lane (
      .a_man   (pair.a_man[i]),
      .b_man   (pair.b_man[i]),
      .a_shift (pair.a_shift),
      .b_shift (pair.b_shift),
      .sum     (sums[i])
    );
  end

  bfp_block_normalize u_norm (
    .clk     (clk),
    .reset   (reset),
    .sums    (sums),
    .max_exp (pair.max_exp),
    .result  (norm_result)
  );

  // Output register slice.
  bfp_skid_buffer u_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (norm_result),
    .in_valid  (pair_valid),
    .in_ready  (pair_ready),
    .out_data  (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

//--- verif/bfp_adder_model.svh
`ifndef BFP_ADDER_MODEL_SVH
`define BFP_ADDER_MODEL_SVH

// ============================================================
// Random source.
// ============================================================

logic [31:0] lfsr_state = 32'he692;

// Fibonacci LFSR, taps for x^32 + x^22 + x^2 + x + 1.
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// One LFSR step per bit.
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// True with probability level/128.
function automatic logic chance(input int level);
  return (int'(rand_bits(7)) < level);
endfunction

// ============================================================
// Reference arithmetic.
// ============================================================

localparam int EXP_HI = (1 << (EXP_W - 1)) - 1;
localparam int EXP_LO = -(1 << (EXP_W - 1));

function automatic int align(input int m, input int sh);
  if (sh >= MAN_W) begin
    return (m < 0) ? -1 : 0;
  end
  return m >>> sh;
endfunction

// Largest r for which v still fits in MAN_W - r signed bits.
function automatic int redundant_bits(input int v);
  int best;
  best = 0;
  for (int r = 1; r < MAN_W; r++) begin
    if (v >= -(1 << (MAN_W - 1 - r)) && v < (1 << (MAN_W - 1 - r))) begin
      best = r;
    end
  end
  return best;
endfunction

function automatic bfp_out_t model_add(input bfp_in_t a, input bfp_in_t b);
  bfp_out_t res;
  int       a_exp;
  int       b_exp;
  int       max_exp;
  int       prov;
  int       k;
  int       floor_room;
  int       sum_v[BLOCK_SIZE];
  a_exp   = int'($signed(a.exp));
  b_exp   = int'($signed(b.exp));
  max_exp = (a_exp > b_exp) ? a_exp : b_exp;
  k       = MAN_W - 1;
  for (int i = 0; i < BLOCK_SIZE; i++) begin
    sum_v[i] = (align(int'($signed(a.man[i])), max_exp - a_exp) +
                align(int'($signed(b.man[i])), max_exp - b_exp)) >>> 1;
    if (redundant_bits(sum_v[i]) < k) begin
      k = redundant_bits(sum_v[i]);
    end
  end
  prov       = max_exp + 1;
  floor_room = prov - int'(OEXP_MIN);
  if (k > floor_room) begin
    k = floor_room;
  end
  for (int i = 0; i < BLOCK_SIZE; i++) begin
    res.man[i] = MAN_W'(sum_v[i] << k);
  end
  res.exp = OEXP_W'(prov - k);
  return res;
endfunction

// Expected results in transfer order.
bfp_out_t exp_q[$];

function automatic void push_expected(input bfp_in_t a, input bfp_in_t b);
  exp_q.push_back(model_add(a, b));
endfunction

`endif

//--- verif/bfp_adder_tb.sv
`timescale 1ns/10ps

module bfp_adder_tb;

  import bfp_pkg::*;

  logic     clk;
  logic     reset;
  bfp_in_t  a_block;
  logic     a_valid;
  logic     a_ready;
  bfp_in_t  b_block;
  logic     b_valid;
  logic     b_ready;
  bfp_out_t out_block;
  logic     out_valid;
  logic     out_ready;

  bfp_in_t  a_src[$];
  bfp_in_t  b_src[$];
  int       valid_level;
  int       ready_level;
  int       joined;
  int       received;
  int       errors;
  int       tests_run;
  int       tests_failed;
  logic     timed_out;

  `include "bfp_adder_model.svh"

  bfp_adder_top dut (
    .clk       (clk),
    .reset     (reset),
    .a_block   (a_block),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .b_block   (b_block),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .out_block (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Mode 0 equal exponents, 1 spread and extremes, 2 small values near the floor.
  function automatic void make_pair(input int mode, output bfp_in_t a, output bfp_in_t b);
    int         base;
    logic       zero_block;
    logic [2:0] r;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      a.man[i] = MAN_W'(rand_bits(MAN_W));
      b.man[i] = MAN_W'(rand_bits(MAN_W));
    end
    a.exp = EXP_W'(rand_bits(EXP_W));
    b.exp = EXP_W'(rand_bits(EXP_W));
    if (mode == 0) begin
      b.exp = a.exp;
    end else if (mode == 1) begin
      base = int'($signed(a.exp)) + (rand_bits(1) ? -1 : 1) * int'(rand_bits(4));
      base = (base > EXP_HI) ? EXP_HI : (base < EXP_LO) ? EXP_LO : base;
      b.exp = EXP_W'(base);
      if (rand_bits(3) == 0) begin
        a.exp = rand_bits(1) ? EXP_W'(EXP_LO) : EXP_W'(EXP_HI);
        b.exp = ~a.exp;
      end
    end else if (mode == 2) begin
      a.exp      = EXP_W'(EXP_LO + int'(rand_bits(3)));
      b.exp      = EXP_W'(EXP_LO + int'(rand_bits(3)));
      zero_block = (rand_bits(2) == 0);
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        r          = 3'(rand_bits(3));
        a.man[i]   = zero_block ? '0 : {{(MAN_W - 3){r[2]}}, r};
        r          = 3'(rand_bits(3));
        b.man[i]   = zero_block ? '0 : {{(MAN_W - 3){r[2]}}, r};
      end
    end
  endfunction

  task automatic compare_output(input bfp_out_t got);
    bfp_out_t want;
    if (exp_q.size() == 0) begin
      $display("output block arrived with no expected result pending");
      errors++;
    end else begin
      want = exp_q.pop_front();
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        if (got.man[i] !== want.man[i]) begin
          $display("[ERROR] out_block.man[%0d] got %h expected %h", i, got.man[i], want.man[i]);
          errors++;
        end
      end
      if (got.exp !== want.exp) begin
        $display("[ERROR] out_block.exp got %h expected %h", got.exp, want.exp);
        errors++;
      end
    end
  endtask

  // One clock: observe transfers at the edge, then drive the next inputs.
  task automatic step_cycle();
    logic a_fire;
    logic b_fire;
    @(posedge clk);
    a_fire = a_valid && a_ready;
    b_fire = b_valid && b_ready;
    if (a_fire != b_fire) begin
      $display("an operand was consumed without its partner at %0t", $time);
      errors++;
    end
    if (a_fire && b_fire) begin
      push_expected(a_block, b_block);
      joined++;
    end
    if (out_valid && out_ready) begin
      compare_output(out_block);
      received++;
    end
    if (!a_valid || a_fire) begin
      if (a_src.size() > 0 && chance(valid_level)) begin
        a_block <= a_src.pop_front();
        a_valid <= 1'b1;
      end else begin
        a_valid <= 1'b0;
      end
    end
    if (!b_valid || b_fire) begin
      if (b_src.size() > 0 && chance(valid_level)) begin
        b_block <= b_src.pop_front();
        b_valid <= 1'b1;
      end else begin
        b_valid <= 1'b0;
      end
    end
    out_ready <= chance(ready_level);
  endtask

  task automatic check_idle();
    int err_start;
    err_start = errors;
    for (int c = 0; c < 3; c++) begin
      step_cycle();
      if (out_valid !== 1'b0) begin
        $display("[ERROR] out_valid got %h expected %h", out_valid, 1'b0);
        errors++;
      end
      if (a_ready !== 1'b0 || b_ready !== 1'b0) begin
        $display("[ERROR] a_ready/b_ready got %h/%h expected 0/0", a_ready, b_ready);
        errors++;
      end
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test reset_idle: %0d errors", errors - err_start);
  endtask

  task automatic run_test(input string name, input int mode, input int count,
                          input int v_level, input int r_level);
    bfp_in_t a;
    bfp_in_t b;
    int      join_start;
    int      recv_start;
    int      err_start;
    int      cyc;
    logic    done;
    join_start = joined;
    recv_start = received;
    err_start  = errors;
    for (int n = 0; n < count; n++) begin
      make_pair(mode, a, b);
      a_src.push_back(a);
      b_src.push_back(b);
    end
    valid_level = v_level;
    ready_level = r_level;
    done        = 1'b0;
    cyc         = 0;
    while (!done && cyc < 100 + count * 20) begin
      step_cycle();
      cyc++;
      done = (joined - join_start == count) && (received - recv_start == count);
    end
    if (!done) begin
      $display("timeout in %s: saw %0d of %0d result blocks", name, received - recv_start, count);
      timed_out = 1'b1;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results left unmatched after %s", exp_q.size(), name);
      errors++;
    end
    tests_run++;
    if (errors != err_start || !done) tests_failed++;
    $display("test %s: %0d blocks, %0d errors", name, received - recv_start, errors - err_start);
  endtask

  initial begin
    reset        = 1'b1;
    a_block      = '0;
    a_valid      = 1'b0;
    b_block      = '0;
    b_valid      = 1'b0;
    out_ready    = 1'b0;
    valid_level  = 0;
    ready_level  = 128;
    joined       = 0;
    received     = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    check_idle();
    run_test("first_join", 3, 1, 128, 128);
    if (!timed_out) run_test("equal_exp", 0, 200, 128, 128);
    if (!timed_out) run_test("exp_spread", 1, 300, 128, 128);
    if (!timed_out) run_test("normalize", 2, 200, 128, 128);
    if (!timed_out) run_test("independent_valids", 3, 300, 64, 128);
    if (!timed_out) run_test("ready_stalls", 3, 500, 112, 64);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+verif
verilog/bfp_pkg.sv
verilog/bfp_lane_adder.sv
verilog/bfp_operand_join.sv
verilog/bfp_block_normalize.sv
verilog/bfp_skid_buffer.sv
verilog/bfp_adder_top.sv
verif/bfp_adder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the BFP adder testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

TOP=bfp_adder_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  echo "run_sim: pass message found in $LOG"
  exit 0
else
  echo "run_sim: pass message not found in $LOG"
  exit 1
fi
